/* src/fpga_sys_config.svh */
// widths of the host bus, RAM and APB side
// address map of the peripheral regions

`ifndef FPGA_SYS_CONFIG_SVH
`define FPGA_SYS_CONFIG_SVH

// host bus and data widths
`define FS_HALF_W 11
`define FS_ADDR_W 22
`define FS_DATA_W 8
`define FS_RAM_AW 12
`define FS_PADDR_W 16

// address map, compared against the upper system address bits
`define FS_GPIO0_PAGE 16
`define FS_GPIO1_PAGE 17
`define FS_APB_BANK 1

`endif

/* src/fpga_sys_pkg.sv */
// vector types for addresses and data
// state encoding of the APB requester

`include "fpga_sys_config.svh"

package fpga_sys_pkg;

	// row or column half of the multiplexed address
	typedef logic [`FS_HALF_W-1:0] half_addr_t;

	// full system address, row above column
	typedef logic [`FS_ADDR_W-1:0] sys_addr_t;

	typedef logic [`FS_DATA_W-1:0] data_t;

	// scratch RAM index
	typedef logic [`FS_RAM_AW-1:0] ram_addr_t;

	typedef logic [`FS_PADDR_W-1:0] paddr_t;

	typedef enum logic [1:0] {
		apb_idle,
		apb_setup,
		apb_access,
		apb_served
	} apb_state_t;

endpackage

/* src/sys_bus_if.sv */
// internal system bus between front end, decoder and targets
`timescale 1ns/1ps

interface sys_bus_if;

	fpga_sys_pkg::sys_addr_t addr;
	fpga_sys_pkg::data_t wdata;
	logic we;
	// column phase of a host access
	logic active;

	modport front (output addr, output wdata, output we, output active);

	modport decode (input addr, input wdata, input we, input active);

	// targets qualify with their own select
	modport target (input addr, input wdata, input we);

endinterface

/* src/bus_front.sv */
// host bus front end
// input registers, row latch and system address assembly
`timescale 1ns/1ps

module bus_front (
	input  logic                     clk,
	input  logic                     reset,
	input  fpga_sys_pkg::half_addr_t addr,
	input  logic                     bus_en,
	input  logic                     n_nren,
	input  logic                     n_cas,
	input  logic                     n_we,
	input  fpga_sys_pkg::data_t      wdata,
	sys_bus_if.front                 bus
);

	fpga_sys_pkg::half_addr_t addr_r;
	fpga_sys_pkg::half_addr_t row_addr;
	fpga_sys_pkg::data_t wdata_r;
	logic bus_en_r;
	logic n_nren_r;
	logic n_cas_r;
	logic n_we_r;
	logic prev_n_nren;

	// strobes idle high
	always_ff @(posedge clk) begin
		if (reset) begin
			bus_en_r <= 1'b0;
			n_nren_r <= 1'b1;
			n_cas_r <= 1'b1;
			n_we_r <= 1'b1;
			prev_n_nren <= 1'b1;
		end else begin
			bus_en_r <= bus_en;
			n_nren_r <= n_nren;
			n_cas_r <= n_cas;
			n_we_r <= n_we;
			prev_n_nren <= n_nren_r;
		end
	end

	always_ff @(posedge clk) begin
		addr_r <= addr;
		wdata_r <= wdata;
		// row is on the pins when n_nren goes low
		if (!n_nren_r && prev_n_nren)
			row_addr <= addr_r;
	end

	assign bus.addr = {row_addr, addr_r};
	assign bus.wdata = wdata_r;
	assign bus.we = !n_we_r;
	assign bus.active = !n_cas_r && !n_nren_r && bus_en_r;

endmodule

/* src/addr_decode.sv */
// address decoder with registered region selects
// read data mux and host wait generation
`timescale 1ns/1ps
`include "fpga_sys_config.svh"

module addr_decode (
	input  logic                clk,
	input  logic                reset,
	sys_bus_if.decode           bus,
	input  fpga_sys_pkg::data_t ram_rdata,
	input  fpga_sys_pkg::data_t gpio0_rdata,
	input  fpga_sys_pkg::data_t gpio1_rdata,
	input  fpga_sys_pkg::data_t apb_rdata,
	input  logic                apb_done,
	output logic                ram_sel,
	output logic                gpio0_sel,
	output logic                gpio1_sel,
	output logic                apb_sel,
	output fpga_sys_pkg::data_t rdata,
	output logic                n_wait
);

	fpga_sys_pkg::half_addr_t page;
	logic [`FS_ADDR_W-`FS_PADDR_W-1:0] bank;
	logic ram_hit;
	logic gpio0_hit;
	logic gpio1_hit;
	logic apb_hit;

	//////////////////////////////
	// region compare
	//////////////////////////////

	assign page = bus.addr[`FS_ADDR_W-1:`FS_HALF_W];
	assign bank = bus.addr[`FS_ADDR_W-1:`FS_PADDR_W];

	assign ram_hit = bus.active && (bus.addr[`FS_ADDR_W-1:`FS_RAM_AW] == '0);
	assign gpio0_hit = bus.active && (page == fpga_sys_pkg::half_addr_t'(`FS_GPIO0_PAGE));
	assign gpio1_hit = bus.active && (page == fpga_sys_pkg::half_addr_t'(`FS_GPIO1_PAGE));
	assign apb_hit = bus.active && (bank == ($bits(bank))'(`FS_APB_BANK));

	always_ff @(posedge clk) begin
		if (reset) begin
			ram_sel <= 1'b0;
			gpio0_sel <= 1'b0;
			gpio1_sel <= 1'b0;
			apb_sel <= 1'b0;
		end else begin
			ram_sel <= ram_hit;
			gpio0_sel <= gpio0_hit;
			gpio1_sel <= gpio1_hit;
			apb_sel <= apb_hit;
		end
	end

	//////////////////////////////
	// host return path
	//////////////////////////////

	// unmapped reads give zero
	assign rdata = (ram_hit ? ram_rdata : '0) |
		(gpio0_hit ? gpio0_rdata : '0) |
		(gpio1_hit ? gpio1_rdata : '0) |
		(apb_hit ? apb_rdata : '0);

	// only the APB region stretches the access
	assign n_wait = !(apb_hit && !apb_done);

endmodule

/* src/scratch_ram.sv */
// on-chip scratch RAM, single port, registered read
`timescale 1ns/1ps
`include "fpga_sys_config.svh"

module scratch_ram (
	input  logic                clk,
	input  logic                sel,
	sys_bus_if.target           bus,
	output fpga_sys_pkg::data_t rdata
);

	fpga_sys_pkg::data_t mem [0:(1 << `FS_RAM_AW)-1];
	fpga_sys_pkg::ram_addr_t idx;

	assign idx = bus.addr[`FS_RAM_AW-1:0];

	always_ff @(posedge clk) begin
		if (sel && bus.we)
			mem[idx] <= bus.wdata;
		// read every cycle, old data on a write
		rdata <= mem[idx];
	end

endmodule

/* src/gpio_port.sv */
// one 8-bit GPIO port
// output register and two-stage input sampling
`timescale 1ns/1ps

module gpio_port (
	input  logic                clk,
	input  logic                reset,
	input  logic                sel,
	sys_bus_if.target           bus,
	input  fpga_sys_pkg::data_t input_pins,
	output fpga_sys_pkg::data_t output_pins,
	output fpga_sys_pkg::data_t rdata
);

	fpga_sys_pkg::data_t in_meta;

	always_ff @(posedge clk) begin
		if (reset)
			output_pins <= '0;
		else if (sel && bus.we)
			output_pins <= bus.wdata;
	end

	// pins are asynchronous to clk
	always_ff @(posedge clk) begin
		in_meta <= input_pins;
		rdata <= in_meta;
	end

endmodule

/* src/apb_bridge.sv */
// APB requester, one transfer per held host access
// served state keeps done up until the select drops
`timescale 1ns/1ps
`include "fpga_sys_config.svh"

module apb_bridge (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 sel,
	sys_bus_if.target            bus,
	input  fpga_sys_pkg::data_t  prdata,
	input  logic                 pready,
	output fpga_sys_pkg::paddr_t paddr,
	output logic                 psel,
	output logic                 penable,
	output logic                 pwrite,
	output fpga_sys_pkg::data_t  pwdata,
	output fpga_sys_pkg::data_t  rdata,
	output logic                 done
);

	fpga_sys_pkg::apb_state_t state;
	fpga_sys_pkg::data_t rdata_r;
	logic xfer_end;

	assign xfer_end = (state == fpga_sys_pkg::apb_access) && pready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fpga_sys_pkg::apb_idle;
		end else begin
			case (state)
				fpga_sys_pkg::apb_idle:
					if (sel)
						state <= fpga_sys_pkg::apb_setup;
				fpga_sys_pkg::apb_setup:
					state <= fpga_sys_pkg::apb_access;
				fpga_sys_pkg::apb_access:
					if (pready)
						state <= fpga_sys_pkg::apb_served;
				// wait for the host to end the access
				default:
					if (!sel)
						state <= fpga_sys_pkg::apb_idle;
			endcase
		end
	end

	//////////////////////////////
	// transfer payload
	//////////////////////////////

	// captured once, held through wait states
	always_ff @(posedge clk) begin
		if (state == fpga_sys_pkg::apb_idle && sel) begin
			paddr <= bus.addr[`FS_PADDR_W-1:0];
			pwdata <= bus.wdata;
			pwrite <= bus.we;
		end
		if (xfer_end)
			rdata_r <= prdata;
	end

	assign psel = (state == fpga_sys_pkg::apb_setup) || (state == fpga_sys_pkg::apb_access);
	assign penable = (state == fpga_sys_pkg::apb_access);
	assign done = xfer_end || (state == fpga_sys_pkg::apb_served);
	assign rdata = xfer_end ? prdata : rdata_r;

endmodule

/* src/sys_top.sv */
// peripheral subsystem top level
// front end, decoder, scratch RAM, two GPIO ports and APB bridge
`timescale 1ns/1ps

module sys_top (
	input  logic                     clk,
	input  logic                     reset,
	input  fpga_sys_pkg::half_addr_t addr,
	input  logic                     bus_en,
	input  logic                     n_nren,
	input  logic                     n_cas,
	input  logic                     n_we,
	input  fpga_sys_pkg::data_t      wdata,
	output fpga_sys_pkg::data_t      rdata,
	output logic                     n_wait,
	output fpga_sys_pkg::paddr_t     paddr,
	output logic                     psel,
	output logic                     penable,
	output logic                     pwrite,
	output fpga_sys_pkg::data_t      pwdata,
	input  fpga_sys_pkg::data_t      prdata,
	input  logic                     pready,
	output fpga_sys_pkg::data_t      output_pins,
	input  fpga_sys_pkg::data_t      input_pins,
	output fpga_sys_pkg::data_t      output_pins2,
	input  fpga_sys_pkg::data_t      input_pins2
);

	logic ram_sel;
	logic gpio0_sel;
	logic gpio1_sel;
	logic apb_sel;
	logic apb_done;
	fpga_sys_pkg::data_t ram_rdata;
	fpga_sys_pkg::data_t gpio0_rdata;
	fpga_sys_pkg::data_t gpio1_rdata;
	fpga_sys_pkg::data_t apb_rdata;

	sys_bus_if bus ();

	//////////////////////////////
	// host side
	//////////////////////////////

	bus_front u_front (
		.clk(clk), .reset(reset), .addr(addr), .bus_en(bus_en), .n_nren(n_nren),
		.n_cas(n_cas), .n_we(n_we), .wdata(wdata), .bus(bus)
	);

	addr_decode u_decode (
		.clk(clk), .reset(reset), .bus(bus),
		.ram_rdata(ram_rdata), .gpio0_rdata(gpio0_rdata), .gpio1_rdata(gpio1_rdata),
		.apb_rdata(apb_rdata), .apb_done(apb_done),
		.ram_sel(ram_sel), .gpio0_sel(gpio0_sel), .gpio1_sel(gpio1_sel),
		.apb_sel(apb_sel), .rdata(rdata), .n_wait(n_wait)
	);

	//////////////////////////////
	// targets
	//////////////////////////////

	scratch_ram u_ram (.clk(clk), .sel(ram_sel), .bus(bus), .rdata(ram_rdata));

	gpio_port u_gpio0 (
		.clk(clk), .reset(reset), .sel(gpio0_sel), .bus(bus),
		.input_pins(input_pins), .output_pins(output_pins), .rdata(gpio0_rdata)
	);

	gpio_port u_gpio1 (
		.clk(clk), .reset(reset), .sel(gpio1_sel), .bus(bus),
		.input_pins(input_pins2), .output_pins(output_pins2), .rdata(gpio1_rdata)
	);

	apb_bridge u_apb (
		.clk(clk), .reset(reset), .sel(apb_sel), .bus(bus),
		.prdata(prdata), .pready(pready), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.rdata(apb_rdata), .done(apb_done)
	);

endmodule

/* testbench/sys_top_properties.sv */
// APB requester protocol checks
// bound into the subsystem top level
`timescale 1ns/1ps

module sys_top_properties (
	input logic                 clk,
	input logic                 reset,
	input logic                 psel,
	input logic                 penable,
	input logic                 pready,
	input logic                 pwrite,
	input fpga_sys_pkg::paddr_t paddr,
	input fpga_sys_pkg::data_t  pwdata
);

	int unsigned err_count = 0;

	// access phase only inside a selected transfer
	enable_in_select: assert property (@(posedge clk) disable iff (reset) penable |-> psel)
		else begin
			$error("penable high without psel");
			err_count++;
		end

	// setup phase lasts exactly one cycle
	enable_after_select: assert property (@(posedge clk) disable iff (reset)
		$rose(psel) |=> penable)
		else begin
			$error("penable did not follow psel");
			err_count++;
		end

	// wait states freeze the whole request
	hold_on_wait: assert property (@(posedge clk) disable iff (reset)
		psel && penable && !pready |=> psel && penable && $stable(paddr) &&
			$stable(pwdata) && $stable(pwrite))
		else begin
			$error("APB request changed while pready was low");
			err_count++;
		end

endmodule

bind sys_top sys_top_properties u_props (
	.clk(clk), .reset(reset), .psel(psel), .penable(penable), .pready(pready),
	.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata)
);

/* testbench/tb_sys_top.sv */
// testbench for the peripheral subsystem
// host bus tasks, APB responder and checking assertions
`timescale 1ns/1ps
`include "fpga_sys_config.svh"

module tb_sys_top;

	localparam int wait_limit = 40;
	localparam fpga_sys_pkg::sys_addr_t gpio0_base = `FS_GPIO0_PAGE << `FS_HALF_W;
	localparam fpga_sys_pkg::sys_addr_t gpio1_base = `FS_GPIO1_PAGE << `FS_HALF_W;
	localparam fpga_sys_pkg::sys_addr_t apb_base = `FS_APB_BANK << `FS_PADDR_W;
	localparam fpga_sys_pkg::sys_addr_t unmapped_addr = 22'h20005;

	logic clk = 1'b0;
	logic reset = 1'b1;
	fpga_sys_pkg::half_addr_t addr = '0;
	logic bus_en = 1'b0;
	logic n_nren = 1'b1;
	logic n_cas = 1'b1;
	logic n_we = 1'b1;
	fpga_sys_pkg::data_t wdata = '0;
	fpga_sys_pkg::data_t prdata = '0;
	logic pready = 1'b0;
	fpga_sys_pkg::data_t input_pins = '0;
	fpga_sys_pkg::data_t input_pins2 = '0;
	fpga_sys_pkg::data_t rdata;
	logic n_wait;
	fpga_sys_pkg::paddr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	fpga_sys_pkg::data_t pwdata;
	fpga_sys_pkg::data_t output_pins;
	fpga_sys_pkg::data_t output_pins2;

	integer seed = 39;
	int waits_left = 0;
	int xfer_count = 0;
	int exp_xfers = 0;
	fpga_sys_pkg::data_t apb_mem [16];
	fpga_sys_pkg::sys_addr_t ram_a [4] = '{22'h000, 22'h123, 22'h800, 22'hfff};
	fpga_sys_pkg::data_t ram_d [4];
	logic chk_rd = 1'b0;
	logic chk_idle = 1'b0;
	logic chk_unmapped = 1'b0;
	logic reset_quiet;
	fpga_sys_pkg::data_t exp_rd = '0;
	fpga_sys_pkg::data_t exp_out0 = '0;
	fpga_sys_pkg::data_t exp_out1 = '0;
	fpga_sys_pkg::paddr_t exp_paddr = '0;
	fpga_sys_pkg::data_t exp_pwdata = '0;
	logic exp_pwrite = 1'b0;

	sys_top UUT (.*);

	initial begin
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	function automatic fpga_sys_pkg::data_t rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic cycle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	//////////////////////////////
	// APB responder
	//////////////////////////////

	// 0 to 3 wait states per transfer
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (psel && !penable) begin
				waits_left = $unsigned($random(seed)) % 4;
				pready = (waits_left == 0);
			end else if (psel && penable && !pready) begin
				if (waits_left == 0)
					pready = 1'b1;
				else
					waits_left--;
			end else if (!psel) begin
				pready = 1'b0;
			end
			prdata = apb_mem[paddr[3:0]];
		end
	end

	always @(posedge clk) begin
		if (psel && penable && pready)
			xfer_count <= xfer_count + 1;
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	assign reset_quiet = !psel && !penable && output_pins == '0 && output_pins2 == '0 && n_wait;

	reset_state: assert property (@(posedge clk) reset |=> reset_quiet ##1 reset_quiet)
		else abort_run($sformatf("FAILED at %0t: outputs not idle around reset", $time));

	read_data: assert property (@(posedge clk) chk_rd |-> rdata == exp_rd)
		else abort_run($sformatf("FAILED at %0t: rdata %h, expected %h", $time,
			$sampled(rdata), exp_rd));

	// pins and transfer count between accesses
	idle_state: assert property (@(posedge clk)
		chk_idle |-> output_pins == exp_out0 && output_pins2 == exp_out1 &&
			xfer_count == exp_xfers)
		else abort_run($sformatf("FAILED at %0t: pins %h %h, transfers %0d, expected %h %h %0d",
			$time, $sampled(output_pins), $sampled(output_pins2), $sampled(xfer_count),
			exp_out0, exp_out1, exp_xfers));

	apb_request: assert property (@(posedge clk)
		psel && penable && pready |-> paddr == exp_paddr && pwrite == exp_pwrite &&
			(!exp_pwrite || pwdata == exp_pwdata))
		else abort_run($sformatf("FAILED at %0t: APB paddr %h pwrite %b pwdata %h", $time,
			$sampled(paddr), $sampled(pwrite), $sampled(pwdata)));

	apb_wait: assert property (@(posedge clk) psel && !(penable && pready) |-> !n_wait)
		else abort_run($sformatf("FAILED at %0t: n_wait high before APB completion", $time));

	unmapped: assert property (@(posedge clk)
		chk_unmapped |-> rdata == '0 && n_wait && !psel && !UUT.ram_sel &&
			!UUT.gpio0_sel && !UUT.gpio1_sel && !UUT.apb_sel)
		else abort_run($sformatf("FAILED at %0t: unmapped access reached a target", $time));

	always @(negedge clk) begin
		if (UUT.u_props.err_count != 0)
			abort_run("APB protocol assertion failed");
	end

	//////////////////////////////
	// host bus
	//////////////////////////////

	task automatic start_access(input fpga_sys_pkg::sys_addr_t a, input logic wr,
		input fpga_sys_pkg::data_t d);
		addr = a[`FS_ADDR_W-1:`FS_HALF_W];
		n_we = !wr;
		wdata = d;
		bus_en = 1'b1;
		n_nren = 1'b0;
		cycle(2);
		addr = a[`FS_HALF_W-1:0];
		n_cas = 1'b0;
	endtask

	task automatic end_access();
		n_cas = 1'b1;
		n_nren = 1'b1;
		n_we = 1'b1;
		bus_en = 1'b0;
		cycle(1);
		chk_idle = 1'b1;
		cycle(1);
		chk_idle = 1'b0;
		cycle(1);
	endtask

	// column phase held for 4 cycles
	task automatic held_access(input fpga_sys_pkg::sys_addr_t a, input logic wr,
		input fpga_sys_pkg::data_t d, input logic check, input fpga_sys_pkg::data_t exp);
		start_access(a, wr, d);
		cycle(3);
		chk_rd = check;
		exp_rd = exp;
		cycle(1);
		chk_rd = 1'b0;
		end_access();
	endtask

	task automatic wait_n_wait(input logic level);
		int tries;
		tries = 0;
		while (n_wait !== level && tries < wait_limit) begin
			@(negedge clk);
			tries++;
		end
		if (n_wait !== level)
			abort_run($sformatf("timeout waiting for n_wait to become %0b", level));
	endtask

	task automatic apb_access(input fpga_sys_pkg::sys_addr_t a, input logic wr,
		input fpga_sys_pkg::data_t d);
		exp_paddr = a[`FS_PADDR_W-1:0];
		exp_pwrite = wr;
		exp_pwdata = d;
		start_access(a, wr, d);
		wait_n_wait(1'b0);
		wait_n_wait(1'b1);
		cycle(1);
		chk_rd = !wr;
		exp_rd = apb_mem[a[3:0]];
		cycle(1);
		chk_rd = 1'b0;
		exp_xfers++;
		end_access();
	endtask

	initial begin
		for (int i = 0; i < 16; i++)
			apb_mem[i] = rand_byte();
		cycle(5);
		reset = 1'b0;
		cycle(3);

		// scratch RAM
		for (int i = 0; i < 4; i++) begin
			ram_d[i] = rand_byte();
			held_access(ram_a[i], 1'b1, ram_d[i], 1'b0, '0);
		end
		for (int i = 0; i < 4; i++)
			held_access(ram_a[i], 1'b0, '0, 1'b1, ram_d[i]);

		// GPIO writes and input sampling
		exp_out0 = rand_byte();
		held_access(gpio0_base + 5, 1'b1, exp_out0, 1'b0, '0);
		exp_out1 = rand_byte();
		held_access(gpio1_base, 1'b1, exp_out1, 1'b0, '0);
		input_pins = rand_byte();
		input_pins2 = rand_byte();
		held_access(gpio0_base + 3, 1'b0, '0, 1'b1, input_pins);
		held_access(gpio1_base + 1, 1'b0, '0, 1'b1, input_pins2);

		// APB writes, then reads
		for (int i = 0; i < 4; i++)
			apb_access(apb_base | {rand_byte(), rand_byte()}, 1'b1, rand_byte());
		for (int i = 0; i < 6; i++)
			apb_access(apb_base | {rand_byte(), rand_byte()}, 1'b0, '0);

		chk_unmapped = 1'b1;
		held_access(unmapped_addr, 1'b0, '0, 1'b1, '0);
		held_access(unmapped_addr, 1'b1, rand_byte(), 1'b0, '0);
		chk_unmapped = 1'b0;

		cycle(4);
		if (UUT.u_props.err_count != 0) begin
			abort_run("APB protocol assertion failed");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

/* tb.f */
+incdir+src
src/fpga_sys_pkg.sv
src/sys_bus_if.sv
src/bus_front.sv
src/addr_decode.sv
src/scratch_ram.sv
src/gpio_port.sv
src/apb_bridge.sv
src/sys_top.sv
testbench/sys_top_properties.sv
testbench/tb_sys_top.sv

/* Bender.yml */
package:
  name: fpga_sys

export_include_dirs:
  - src

sources:
  - files:
      - src/fpga_sys_pkg.sv
      - src/sys_bus_if.sv
      - src/bus_front.sv
      - src/addr_decode.sv
      - src/scratch_ram.sv
      - src/gpio_port.sv
      - src/apb_bridge.sv
      - src/sys_top.sv
  - target: test
    files:
      - testbench/sys_top_properties.sv
      - testbench/tb_sys_top.sv
